// ==== sb_cdc.f ====
design/sb_bus_pkg.sv
design/cdc_pkg.sv
design/sb_cdc_sync.sv
design/sb_cdc.sv
design/sb_register_file.sv
design/sb_cdc_top.sv
testbench/tb_sb_cdc.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the Simplebus write crossing testbench with Verilator and run it.
# Exits non-zero unless the testbench prints its pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sb_cdc \
    -f sb_cdc.f \
    --Mdir obj_dir -o sim_sb_cdc
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_sb_cdc 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Done: no errors"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// ==== testbench/tb_sb_cdc.sv ====
// Testbench for the Simplebus write crossing
// Writes a table of beats on the in_clock bus, lets them cross into
// the out_clock register bank, then reads back every register and
// compares with a model of the bank

`timescale 1ns/10ps

module tb_sb_cdc;

    import sb_bus_pkg::*;

    localparam int SYNC_STAGES     = 2;
    localparam int QUEUE_DEPTH     = 4;
    localparam int REG_COUNT       = 16;
    localparam int IN_PERIOD       = 100;
    localparam int OUT_PERIOD      = 130;
    localparam int DRIVE_DELAY     = 10;  // After the rising edge of the own clock
    localparam int SETTLE_CYCLES   = 40;  // out_clock cycles before read back
    localparam int WATCHDOG_FACTOR = 60;  // in_clock cycles allowed per table row

    // One table row
    typedef struct packed {
        logic [SB_ADDR_WIDTH-1:0] address;
        logic [SB_DATA_WIDTH-1:0] data;
        logic                     back_to_back;  // No idle cycle before this write
        logic                     random_fill;   // Address and data from $random
        logic                     group_end;     // Read back after this write
    } stim_t;

    logic                     in_clock;
    logic                     out_clock;
    logic                     arst_n;
    sb_write_t                in_write;
    logic                     in_strobe;
    logic                     in_ready;
    logic [7:0]               read_index;
    logic [SB_DATA_WIDTH-1:0] read_data;

    stim_t                    stim_q [$];          // Stimulus table
    logic [SB_DATA_WIDTH-1:0] model [REG_COUNT];   // Expected register contents
    logic                     table_loaded   = 1'b0;
    logic                     ready_low_seen = 1'b0;
    int                       error_count    = 0;
    integer                   seed           = 32'h35bf;

    sb_cdc_top #(
        .SYNC_STAGES (SYNC_STAGES),
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .REG_COUNT   (REG_COUNT)
    ) i_dut (
        .in_clock   (in_clock),
        .out_clock  (out_clock),
        .arst_n     (arst_n),
        .in_write   (in_write),
        .in_strobe  (in_strobe),
        .in_ready   (in_ready),
        .read_index (read_index),
        .read_data  (read_data)
    );

    // Source clock
    initial begin
        in_clock = 1'b0;
        forever #(IN_PERIOD / 2) in_clock = ~in_clock;
    end

    // Destination clock, unrelated ratio
    initial begin
        out_clock = 1'b0;
        forever #(OUT_PERIOD / 2) out_clock = ~out_clock;
    end

    // Flow control watch, sampled on the falling edge where in_ready is quiet
    always @(negedge in_clock) begin
        if (arst_n && !in_ready) begin
            ready_low_seen = 1'b1;
        end
    end

    // Watchdog scaled by the table length
    initial begin
        wait (table_loaded);
        repeat (stim_q.size() * WATCHDOG_FACTOR) @(posedge in_clock);
        $display("Timeout: the run did not finish within %0d in_clock cycles",
                 stim_q.size() * WATCHDOG_FACTOR);
        $display("Done: errors found");
        $fatal(1, "Watchdog expired");
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("Mismatch at %0t: %s expected %h, actual %h",
                     $time, name, expected, actual);
            $display("Done: errors found");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic add_entry(input logic [31:0] address, input logic [31:0] data,
                             input logic back_to_back, input logic random_fill,
                             input logic group_end);
        stim_t entry;
        entry.address      = address;
        entry.data         = data;
        entry.back_to_back = back_to_back;
        entry.random_fill  = random_fill;
        entry.group_end    = group_end;
        stim_q.push_back(entry);
    endtask

    task automatic load_table();
        // One write per register, some with a byte offset
        for (int i = 0; i < REG_COUNT; i++) begin
            add_entry(32'(i * 4 + i % 4), {16'hc0de, 8'(i), 8'(~i)}, 1'b0, 1'b0,
                      i == REG_COUNT - 1);
        end
        // Same index written back to back, last value wins
        add_entry(32'h14, 32'h1111_0001, 1'b0, 1'b0, 1'b0);
        add_entry(32'h14, 32'h2222_0002, 1'b1, 1'b0, 1'b0);
        add_entry(32'h14, 32'h3333_0003, 1'b1, 1'b0, 1'b0);
        add_entry(32'h24, 32'h4444_0004, 1'b0, 1'b0, 1'b0);
        add_entry(32'h26, 32'h5555_0005, 1'b1, 1'b0, 1'b1);  // Index 9 again
        // Burst twice the queue depth
        for (int i = 0; i < 2 * QUEUE_DEPTH; i++) begin
            add_entry(32'(32 + i * 4), 32'hb000_0000 | 32'(i), i != 0, 1'b0,
                      i == 2 * QUEUE_DEPTH - 1);
        end
        // Indices outside the bank
        add_entry(32'h40, 32'hdead_0010, 1'b0, 1'b0, 1'b0);         // Index 16
        add_entry(32'h50, 32'hdead_0014, 1'b1, 1'b0, 1'b0);         // Index 20
        add_entry(32'h3fc, 32'hdead_00ff, 1'b1, 1'b0, 1'b0);        // Index 255
        add_entry(32'h8000_0008, 32'hdead_beef, 1'b0, 1'b0, 1'b1);  // High address
        // Seeded random run
        for (int i = 0; i < 10; i++) begin
            add_entry('0, '0, i % 3 != 0, 1'b1, i == 9);
        end
    endtask

    // Register bank rule: word index, writes outside the bank are dropped
    function automatic void apply_model(input sb_write_t beat);
        logic [SB_ADDR_WIDTH-3:0] index;
        index = beat.address[SB_ADDR_WIDTH-1:2];
        if (index < REG_COUNT) begin
            model[int'(index)] = beat.data;
        end
    endfunction

    // One bus write, held off while the queue is full
    task automatic send_write(input sb_write_t beat);
        while (!in_ready) begin
            @(posedge in_clock);
            #DRIVE_DELAY;
        end
        in_write  = beat;
        in_strobe = 1'b1;
        @(posedge in_clock);  // Accepted here
        #DRIVE_DELAY;
        in_strobe = 1'b0;
    endtask

    task automatic read_register(input int index, output logic [31:0] value);
        @(posedge out_clock);
        #DRIVE_DELAY;
        read_index = 8'(index);
        @(posedge out_clock);  // read_data takes the new index here
        #DRIVE_DELAY;
        value = read_data;
    endtask

    task automatic check_registers();
        logic [31:0] value;
        int          far_index [3];
        far_index = '{REG_COUNT, REG_COUNT + 4, 255};
        for (int i = 0; i < REG_COUNT; i++) begin
            read_register(i, value);
            check($sformatf("read_data[%0d]", i), model[i], value);
        end
        for (int j = 0; j < 3; j++) begin
            read_register(far_index[j], value);  // Outside the bank, reads zero
            check($sformatf("read_data[%0d]", far_index[j]), 32'd0, value);
        end
    endtask

    // Queue drained, then settle for the beat still crossing
    task automatic wait_drained();
        while (i_dut.i_cdc.count_q != '0) begin
            @(posedge in_clock);
            #DRIVE_DELAY;
        end
        repeat (SETTLE_CYCLES) @(posedge out_clock);
    endtask

    initial begin
        stim_t     entry;
        sb_write_t beat;
        int        run_length;
        logic      expect_stall;

        in_write     = '0;
        in_strobe    = 1'b0;
        read_index   = '0;
        arst_n       = 1'b0;
        run_length   = 0;
        expect_stall = 1'b0;
        for (int i = 0; i < REG_COUNT; i++) begin
            model[i] = '0;
        end
        load_table();
        table_loaded = 1'b1;

        // Release between the edges of both clocks
        repeat (4) @(posedge in_clock);
        #30;
        arst_n = 1'b1;

        @(posedge in_clock);
        #DRIVE_DELAY;
        check("in_ready", 32'd1, 32'(in_ready));  // Empty queue after reset
        check_registers();
        ready_low_seen = 1'b0;

        for (int k = 0; k < stim_q.size(); k++) begin
            entry        = stim_q[k];
            beat.address = entry.address;
            beat.data    = entry.data;
            if (entry.random_fill) begin
                beat.address = {25'd0, 7'($random(seed))};  // Index 0 to 31, any offset
                beat.data    = $random(seed);
            end
            if (!entry.back_to_back) begin
                repeat (3) begin
                    @(posedge in_clock);
                    #DRIVE_DELAY;
                end
                run_length = 0;
            end
            run_length++;
            if (run_length > QUEUE_DEPTH) begin
                expect_stall = 1'b1;  // Burst outruns the crossing
            end
            send_write(beat);
            apply_model(beat);
            if (entry.group_end) begin
                wait_drained();
                @(posedge in_clock);
                #DRIVE_DELAY;
                check("in_ready", 32'd1, 32'(in_ready));
                if (expect_stall) begin
                    check("in_ready low during burst", 32'd1, 32'(ready_low_seen));
                end
                check_registers();
                expect_stall   = 1'b0;
                ready_low_seen = 1'b0;
            end
        end

        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== design/sb_cdc_top.sv ====
// Top level of the Simplebus write crossing
// Writes taken in in_clock pass through the queue and handshake
// into the out_clock register bank, which is read back by index

`timescale 1ns/10ps

module sb_cdc_top #(
    parameter int SYNC_STAGES = cdc_pkg::CDC_SYNC_STAGES_DEFAULT,
    parameter int QUEUE_DEPTH = 4,
    parameter int REG_COUNT   = 16
) (
    input  logic                                in_clock,
    input  logic                                out_clock,
    input  logic                                arst_n,
    input  sb_bus_pkg::sb_write_t               in_write,    // Master write bus
    input  logic                                in_strobe,
    output logic                                in_ready,
    input  logic [7:0]                          read_index,  // out_clock read port
    output logic [sb_bus_pkg::SB_DATA_WIDTH-1:0] read_data
);

    import sb_bus_pkg::*;

    sb_write_t cdc_write;   // Crossed write beat
    logic      cdc_strobe;

    // Queue and clock crossing
    sb_cdc #(
        .SYNC_STAGES (SYNC_STAGES),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_cdc (
        .in_clock   (in_clock),
        .out_clock  (out_clock),
        .arst_n     (arst_n),
        .in_write   (in_write),
        .in_strobe  (in_strobe),
        .in_ready   (in_ready),
        .out_write  (cdc_write),
        .out_strobe (cdc_strobe)
    );

    // Destination register bank
    sb_register_file #(
        .REG_COUNT (REG_COUNT)
    ) i_regs (
        .out_clock  (out_clock),
        .arst_n     (arst_n),
        .bus_write  (cdc_write),
        .bus_strobe (cdc_strobe),
        .read_index (read_index),
        .read_data  (read_data)
    );

endmodule

// ==== design/sb_register_file.sv ====
// Control register bank in the out_clock domain
// Written by Simplebus write beats, word indexed by address[..:2];
// out of range writes are ignored and out of range reads give zero.
// Read port is registered

`timescale 1ns/10ps

module sb_register_file #(
    parameter int REG_COUNT = 16  // 1 to 256
) (
    input  logic                                out_clock,
    input  logic                                arst_n,
    input  sb_bus_pkg::sb_write_t               bus_write,
    input  logic                                bus_strobe,  // One cycle per write
    input  logic [7:0]                          read_index,
    output logic [sb_bus_pkg::SB_DATA_WIDTH-1:0] read_data
);

    import sb_bus_pkg::*;

    localparam int IDX_WIDTH = (REG_COUNT > 1) ? $clog2(REG_COUNT) : 1;

    logic [SB_DATA_WIDTH-1:0] regs_q [REG_COUNT];
    logic [SB_ADDR_WIDTH-3:0] write_index;  // Word index
    logic                     write_hit;
    logic                     read_hit;
    logic [SB_DATA_WIDTH-1:0] read_data_q;

    assign write_index = bus_write.address[SB_ADDR_WIDTH-1:2];  // Drop byte offset
    assign write_hit   = bus_strobe && (int'(write_index) < REG_COUNT);
    assign read_hit    = (int'(read_index) < REG_COUNT);

    // Register bank, cleared on reset
    always_ff @(posedge out_clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (write_hit) begin
            regs_q[write_index[IDX_WIDTH-1:0]] <= bus_write.data;
        end
    end

    // Registered read, zero outside the bank
    always_ff @(posedge out_clock or negedge arst_n) begin
        if (!arst_n) begin
            read_data_q <= '0;
        end else if (read_hit) begin
            read_data_q <= regs_q[read_index[IDX_WIDTH-1:0]];
        end else begin
            read_data_q <= '0;
        end
    end

    assign read_data = read_data_q;

    // Crossing must deliver each write as a single pulse
    a_strobe_single: assert property (
        @(posedge out_clock) disable iff (!arst_n)
        bus_strobe |=> !bus_strobe
    );

endmodule

// ==== design/sb_cdc.sv ====
// Simplebus write crossing, in_clock to out_clock
// Accepted writes go into a circular queue in the source domain.
// The queue head is handed to the req/ack synchronizer one beat
// at a time; ready falls only while the queue is full

`timescale 1ns/10ps

module sb_cdc #(
    parameter int SYNC_STAGES = cdc_pkg::CDC_SYNC_STAGES_DEFAULT,
    parameter int QUEUE_DEPTH = 4  // Power of two
) (
    input  logic                  in_clock,
    input  logic                  out_clock,
    input  logic                  arst_n,
    input  sb_bus_pkg::sb_write_t in_write,    // Slave side, in_clock
    input  logic                  in_strobe,
    output logic                  in_ready,
    output sb_bus_pkg::sb_write_t out_write,   // Master side, out_clock
    output logic                  out_strobe
);

    import sb_bus_pkg::*;

    localparam int PTR_WIDTH = $clog2(QUEUE_DEPTH);
    localparam int CNT_WIDTH = $clog2(QUEUE_DEPTH + 1);
    localparam logic [CNT_WIDTH-1:0] FULL_COUNT = CNT_WIDTH'(QUEUE_DEPTH);

    sb_write_t              queue_mem [QUEUE_DEPTH];  // Write beats
    logic [PTR_WIDTH-1:0]   wr_ptr_q;
    logic [PTR_WIDTH-1:0]   rd_ptr_q;
    logic [CNT_WIDTH-1:0]   count_q;     // Occupancy
    logic [CNT_WIDTH-1:0]   count_next;
    logic                   in_ready_q;
    logic                   push;
    logic                   pop;
    logic                   send_busy;
    sb_write_t              send_write;

    assign push       = in_strobe && in_ready_q;           // Bus accept
    assign pop        = (count_q != '0) && !send_busy;     // Hand head to synchronizer
    assign send_write = queue_mem[rd_ptr_q];
    assign in_ready   = in_ready_q;

    // Occupancy after this edge
    always_comb begin
        count_next = count_q;
        if (push && !pop) begin
            count_next = count_q + 1'b1;
        end else if (pop && !push) begin
            count_next = count_q - 1'b1;
        end
    end

    // Pointers, count and registered ready
    always_ff @(posedge in_clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            in_ready_q <= 1'b1;  // Empty queue after reset
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps, depth is a power of two
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q    <= count_next;
            in_ready_q <= (count_next != FULL_COUNT);  // Low only when full
        end
    end

    // Queue storage
    always_ff @(posedge in_clock) begin
        if (push) begin
            queue_mem[wr_ptr_q] <= in_write;
        end
    end

    // One beat at a time across the clock boundary
    sb_cdc_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) i_sync (
        .in_clock    (in_clock),
        .out_clock   (out_clock),
        .arst_n      (arst_n),
        .send_write  (send_write),
        .send_strobe (pop),
        .send_busy   (send_busy),
        .dest_write  (out_write),
        .dest_strobe (out_strobe)
    );

    // Registered ready has to track the count, else a write is lost
    a_no_push_when_full: assert property (
        @(posedge in_clock) disable iff (!arst_n)
        (in_strobe && in_ready) |-> (count_q != FULL_COUNT)
    );

endmodule

// ==== design/sb_cdc_sync.sv ====
// Four-phase req/ack synchronizer for Simplebus write beats
// The word is held stable on the source side while req is high,
// so only req and ack pass through flop chains. The destination
// latches the word and gives a one-cycle strobe per beat

`timescale 1ns/10ps

module sb_cdc_sync #(
    parameter int SYNC_STAGES = cdc_pkg::CDC_SYNC_STAGES_DEFAULT
) (
    input  logic                  in_clock,
    input  logic                  out_clock,
    input  logic                  arst_n,
    input  sb_bus_pkg::sb_write_t send_write,   // Word to move, valid with send_strobe
    input  logic                  send_strobe,  // Take the word, only while not busy
    output logic                  send_busy,    // High from capture until handshake done
    output sb_bus_pkg::sb_write_t dest_write,   // Holds until the next dest_strobe
    output logic                  dest_strobe   // One out_clock pulse per word
);

    import sb_bus_pkg::*;
    import cdc_pkg::*;

    // Source side (in_clock)
    src_state_e             state_q;
    logic                   req_q;       // Crosses to out_clock
    sb_write_t              hold_q;      // Stable while req_q is high
    logic [SYNC_STAGES-1:0] ack_sync_q;  // ack resynchronized
    logic                   ack_seen;

    // Destination side (out_clock)
    logic [SYNC_STAGES-1:0] req_sync_q;  // req resynchronized
    logic                   req_seen;
    logic                   ack_q;       // Crosses back, also the edge detector state
    logic                   new_req;     // Rising edge of req_seen
    sb_write_t              dest_q;
    logic                   dest_strobe_q;

    assign ack_seen  = ack_sync_q[SYNC_STAGES-1];
    assign send_busy = (state_q != SRC_IDLE);

    // Source handshake FSM
    always_ff @(posedge in_clock or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= SRC_IDLE;
            req_q   <= 1'b0;
        end else begin
            case (state_q)
                SRC_IDLE: begin
                    if (send_strobe) begin  // Capture and raise req
                        req_q   <= 1'b1;
                        state_q <= SRC_WAIT_ACK;
                    end
                end
                SRC_WAIT_ACK: begin
                    if (ack_seen) begin     // Destination has the word
                        req_q   <= 1'b0;
                        state_q <= SRC_WAIT_CLEAR;
                    end
                end
                SRC_WAIT_CLEAR: begin
                    if (!ack_seen) begin    // Four phases complete
                        state_q <= SRC_IDLE;
                    end
                end
                default: state_q <= SRC_IDLE;
            endcase
        end
    end

    // Word capture, only loaded in idle so it never moves under req
    always_ff @(posedge in_clock) begin
        if (send_strobe && !send_busy) begin
            hold_q <= send_write;
        end
    end

    // ack back into in_clock
    always_ff @(posedge in_clock or negedge arst_n) begin
        if (!arst_n) begin
            ack_sync_q <= '0;
        end else begin
            ack_sync_q <= {ack_sync_q[SYNC_STAGES-2:0], ack_q};
        end
    end

    assign req_seen = req_sync_q[SYNC_STAGES-1];
    assign new_req  = req_seen && !ack_q;  // req up, not yet answered

    // req into out_clock, ack follows the synchronized req
    always_ff @(posedge out_clock or negedge arst_n) begin
        if (!arst_n) begin
            req_sync_q    <= '0;
            ack_q         <= 1'b0;
            dest_strobe_q <= 1'b0;
        end else begin
            req_sync_q    <= {req_sync_q[SYNC_STAGES-2:0], req_q};
            ack_q         <= req_seen;  // Rises with the latch, falls after req drops
            dest_strobe_q <= new_req;   // Single pulse per handshake
        end
    end

    // Destination word, hold_q is quiet here by protocol
    always_ff @(posedge out_clock) begin
        if (new_req) begin
            dest_q <= hold_q;
        end
    end

    assign dest_write  = dest_q;
    assign dest_strobe = dest_strobe_q;

    // Queue must wait for the handshake to finish
    a_no_send_while_busy: assert property (
        @(posedge in_clock) disable iff (!arst_n)
        send_strobe |-> !send_busy
    );

    // Word seen by out_clock must not change during the handshake
    a_hold_stable: assert property (
        @(posedge out_clock) disable iff (!arst_n)
        req_seen |-> $stable(hold_q)
    );

endmodule

// ==== design/cdc_pkg.sv ====
// Clock crossing definitions
// Default synchronizer depth and the states of the source side
// of the four-phase req/ack handshake

package cdc_pkg;

    // Flops on each of req and ack
    localparam int CDC_SYNC_STAGES_DEFAULT = 2;

    // Source handshake states
    typedef enum logic [1:0] {
        SRC_IDLE       = 2'd0,  // Free, waiting for a new word
        SRC_WAIT_ACK   = 2'd1,  // req high, waiting for ack to rise
        SRC_WAIT_CLEAR = 2'd2   // req low, waiting for ack to fall
    } src_state_e;

endpackage

// ==== design/sb_bus_pkg.sv ====
// Simplebus definitions shared by the write crossing
// Bus widths and the packed write beat that moves through the queue,
// the clock crossing and into the register bank

package sb_bus_pkg;

    // Bus widths
    localparam int SB_ADDR_WIDTH = 32;  // Byte address
    localparam int SB_DATA_WIDTH = 32;  // One register word

    // One write beat, address in the upper half
    typedef struct packed {
        logic [SB_ADDR_WIDTH-1:0] address;  // Byte address, low two bits ignored
        logic [SB_DATA_WIDTH-1:0] data;     // Write data
    } sb_write_t;

endpackage
